//--- hdl/sched_pkg.sv
`default_nettype none

package sched_pkg;

  // ====================
  // machine sizes
  // ====================
  localparam int ARCH_REGS = 32;
  localparam int PHY_REGS  = 64;
  localparam int WB_WIDTH  = 2;

  typedef logic [$clog2(ARCH_REGS)-1:0] areg_t;
  typedef logic [$clog2(PHY_REGS)-1:0]  preg_t;

  // ====================
  // instruction encodings
  // ====================
  typedef enum logic {
    ALU_INSTR = 1'b0,
    MEM_INSTR = 1'b1
  } instr_type_e;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLL = 3'd5,
    ALU_SRL = 3'd6,
    ALU_SLT = 3'd7
  } alu_op_e;

  typedef enum logic [1:0] {
    MEM_LW = 2'd0,
    MEM_LB = 2'd1,
    MEM_SW = 2'd2,
    MEM_SB = 2'd3
  } mem_op_e;

  // fields common to every issued instruction
  typedef struct packed {
    preg_t psrc0;
    preg_t psrc1;
    preg_t pdest;
    logic  dest_valid;
  } issue_base_t;

  // true when any write-back port hits the given register this cycle
  function automatic logic wb_match(
    input logic  [WB_WIDTH-1:0] valid,
    input preg_t [WB_WIDTH-1:0] pdest,
    input preg_t                preg
  );
    logic hit;
    hit = 1'b0;
    for (int j = 0; j < WB_WIDTH; j++) begin
      if (valid[j] && pdest[j] == preg) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

endpackage

`default_nettype wire

//--- hdl/rs_write_if.sv
`timescale 1ns/1ps
`default_nettype none

// dispatch to reservation station write port
interface rs_write_if import sched_pkg::*; #(
  parameter type op_t = alu_op_e
) ();

  logic        wr_valid;
  logic        wr_ready;
  issue_base_t base;
  op_t         op;
  // source readiness as seen at rename time
  logic        src0_ready;
  logic        src1_ready;

  modport dispatch (
    output wr_valid,
    output base,
    output op,
    output src0_ready,
    output src1_ready,
    input  wr_ready
  );

  modport station (
    input  wr_valid,
    input  base,
    input  op,
    input  src0_ready,
    input  src1_ready,
    output wr_ready
  );

endinterface

`default_nettype wire

//--- hdl/free_list.sv
`timescale 1ns/1ps
`default_nettype none

module free_list import sched_pkg::*; #(
  parameter int PHY_REGS = 64
) (
  input  wire   clk,
  input  wire   rst_n,
  input  logic  alloc_i,
  output preg_t alloc_preg_o,
  output logic  empty_o,
  input  logic  free_valid_i,
  input  preg_t free_preg_i
);

  // registers above the architectural range are renamable
  localparam int FL_DEPTH = PHY_REGS - ARCH_REGS;

  typedef logic [$clog2(FL_DEPTH)-1:0]   ptr_t;
  typedef logic [$clog2(FL_DEPTH+1)-1:0] cnt_t;

  preg_t fifo_q [FL_DEPTH];
  ptr_t  head_q;
  ptr_t  tail_q;
  cnt_t  count_q;

  function automatic ptr_t ptr_inc(input ptr_t p);
    return (p == ptr_t'(FL_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign alloc_preg_o = fifo_q[head_q];
  assign empty_o      = (count_q == '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < FL_DEPTH; i++) begin
        fifo_q[i] <= preg_t'(ARCH_REGS + i);
      end
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= cnt_t'(FL_DEPTH);
    end else begin
      if (alloc_i) begin
        head_q <= ptr_inc(head_q);
      end
      if (free_valid_i) begin
        fifo_q[tail_q] <= free_preg_i;
        tail_q         <= ptr_inc(tail_q);
      end
      case ({free_valid_i, alloc_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // dispatch must hold off allocation when nothing is free
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
    alloc_i |-> !empty_o);

  // commit may only return registers that were handed out
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    (free_valid_i && !alloc_i) |-> (count_q < cnt_t'(FL_DEPTH)));

endmodule

`default_nettype wire

//--- hdl/rename_table.sv
`timescale 1ns/1ps
`default_nettype none

module rename_table import sched_pkg::*; #(
  parameter int PHY_REGS = 64
) (
  input  wire                  clk,
  input  wire                  rst_n,
  input  areg_t                src0_i,
  input  areg_t                src1_i,
  input  areg_t                dest_i,
  input  logic                 rename_i,
  input  preg_t                new_preg_i,
  output preg_t                psrc0_o,
  output preg_t                psrc1_o,
  output logic                 src0_ready_o,
  output logic                 src1_ready_o,
  input  logic  [WB_WIDTH-1:0] wb_valid_i,
  input  preg_t [WB_WIDTH-1:0] wb_pdest_i
);

  preg_t               map_q [ARCH_REGS];
  // set at rename, cleared by write-back
  logic [PHY_REGS-1:0] busy_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < ARCH_REGS; i++) begin
        map_q[i] <= preg_t'(i);
      end
      busy_q <= '0;
    end else begin
      for (int j = 0; j < WB_WIDTH; j++) begin
        if (wb_valid_i[j]) begin
          busy_q[wb_pdest_i[j]] <= 1'b0;
        end
      end
      if (rename_i) begin
        map_q[dest_i]        <= new_preg_i;
        busy_q[new_preg_i]   <= 1'b1;
      end
    end
  end

  // ====================
  // source lookup
  // ====================
  assign psrc0_o = map_q[src0_i];
  assign psrc1_o = map_q[src1_i];

  // r0 is never renamed, so it is always ready
  assign src0_ready_o = (src0_i == '0) || !busy_q[psrc0_o] ||
                        wb_match(wb_valid_i, wb_pdest_i, psrc0_o);
  assign src1_ready_o = (src1_i == '0) || !busy_q[psrc1_o] ||
                        wb_match(wb_valid_i, wb_pdest_i, psrc1_o);

endmodule

`default_nettype wire

//--- hdl/rename_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module rename_dispatch import sched_pkg::*; (
  input  wire           clk,
  input  wire           rst_n,
  // request
  input  logic          req_valid_i,
  input  instr_type_e   req_type_i,
  input  logic  [2:0]   req_op_i,
  input  areg_t         req_src0_i,
  input  areg_t         req_src1_i,
  input  areg_t         req_dest_i,
  output logic          req_ready_o,
  // free list
  output logic          alloc_o,
  input  preg_t         alloc_preg_i,
  input  logic          empty_i,
  // rename table
  output areg_t         src0_o,
  output areg_t         src1_o,
  output areg_t         dest_o,
  output logic          rename_o,
  output preg_t         new_preg_o,
  input  preg_t         psrc0_i,
  input  preg_t         psrc1_i,
  input  logic          src0_ready_i,
  input  logic          src1_ready_i,
  // stations
  rs_write_if.dispatch  alu_wr,
  rs_write_if.dispatch  mem_wr
);

  logic        s1_valid_q;
  instr_type_e s1_type_q;
  logic [2:0]  s1_op_q;
  areg_t       s1_src0_q;
  areg_t       s1_src1_q;
  areg_t       s1_dest_q;
  preg_t       s1_preg_q;

  logic        s1_wr_ready;
  logic        s1_fire;
  logic        need_preg;
  logic        accept;
  issue_base_t s1_base;

  // ====================
  // stage 0 accept
  // ====================
  assign need_preg   = (req_dest_i != '0);
  assign s1_wr_ready = (s1_type_q == MEM_INSTR) ? mem_wr.wr_ready : alu_wr.wr_ready;
  assign s1_fire     = s1_valid_q && s1_wr_ready;
  assign req_ready_o = (!s1_valid_q || s1_fire) && (!need_preg || !empty_i);
  assign accept      = req_valid_i && req_ready_o;
  assign alloc_o     = accept && need_preg;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid_q <= 1'b0;
    end else if (accept) begin
      s1_valid_q <= 1'b1;
    end else if (s1_fire) begin
      s1_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      s1_type_q <= req_type_i;
      s1_op_q   <= req_op_i;
      s1_src0_q <= req_src0_i;
      s1_src1_q <= req_src1_i;
      s1_dest_q <= req_dest_i;
      s1_preg_q <= need_preg ? alloc_preg_i : '0;
    end
  end

  // ====================
  // stage 1 rename
  // ====================
  assign src0_o     = s1_src0_q;
  assign src1_o     = s1_src1_q;
  assign dest_o     = s1_dest_q;
  assign new_preg_o = s1_preg_q;
  // map only once the station takes the instruction
  assign rename_o   = s1_fire && (s1_dest_q != '0);

  assign s1_base = '{
    psrc0:      psrc0_i,
    psrc1:      psrc1_i,
    pdest:      s1_preg_q,
    dest_valid: (s1_dest_q != '0)
  };

  // route by type
  assign alu_wr.wr_valid   = s1_valid_q && (s1_type_q == ALU_INSTR);
  assign alu_wr.base       = s1_base;
  assign alu_wr.op         = alu_op_e'(s1_op_q);
  assign alu_wr.src0_ready = src0_ready_i;
  assign alu_wr.src1_ready = src1_ready_i;

  assign mem_wr.wr_valid   = s1_valid_q && (s1_type_q == MEM_INSTR);
  assign mem_wr.base       = s1_base;
  assign mem_wr.op         = mem_op_e'(s1_op_q[1:0]);
  assign mem_wr.src0_ready = src0_ready_i;
  assign mem_wr.src1_ready = src1_ready_i;

  a_one_station: assert property (@(posedge clk) disable iff (!rst_n)
    !(alu_wr.wr_valid && mem_wr.wr_valid));

endmodule

`default_nettype wire

//--- hdl/reservation_station.sv
`timescale 1ns/1ps
`default_nettype none

module reservation_station import sched_pkg::*; #(
  parameter int  RS_SIZE  = 8,
  parameter bit  IN_ORDER = 1'b0,
  parameter type op_t     = alu_op_e
) (
  input  wire                  clk,
  input  wire                  rst_n,
  rs_write_if.station          wr,
  input  logic  [WB_WIDTH-1:0] wb_valid_i,
  input  preg_t [WB_WIDTH-1:0] wb_pdest_i,
  output logic                 issue_valid_o,
  output issue_base_t          issue_base_o,
  output op_t                  issue_op_o,
  input  logic                 issue_ready_i
);

  typedef logic [$clog2(RS_SIZE)-1:0] idx_t;

  logic [RS_SIZE-1:0] valid_q;
  issue_base_t        base_q [RS_SIZE];
  op_t                op_q   [RS_SIZE];
  logic [RS_SIZE-1:0] rdy0_q;
  logic [RS_SIZE-1:0] rdy1_q;

  logic [RS_SIZE-1:0] wake0;
  logic [RS_SIZE-1:0] wake1;
  idx_t               wr_idx;
  idx_t               sel_idx;
  logic               sel_valid;
  logic               full;
  logic               wr_fire;
  logic               load;
  logic               take;

  assign wr.wr_ready = !full;
  assign wr_fire     = wr.wr_valid && !full;
  // issue register accepts when empty or draining
  assign load        = !issue_valid_o || issue_ready_i;
  assign take        = sel_valid && load;

  // ====================
  // wake-up
  // ====================
  always_comb begin
    for (int i = 0; i < RS_SIZE; i++) begin
      wake0[i] = wb_match(wb_valid_i, wb_pdest_i, base_q[i].psrc0);
      wake1[i] = wb_match(wb_valid_i, wb_pdest_i, base_q[i].psrc1);
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < RS_SIZE; i++) begin
      if (wr_fire && wr_idx == idx_t'(i)) begin
        base_q[i] <= wr.base;
        op_q[i]   <= wr.op;
        rdy0_q[i] <= wr.src0_ready;
        rdy1_q[i] <= wr.src1_ready;
      end else begin
        if (wake0[i]) begin
          rdy0_q[i] <= 1'b1;
        end
        if (wake1[i]) begin
          rdy1_q[i] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else begin
      if (take) begin
        valid_q[sel_idx] <= 1'b0;
      end
      if (wr_fire) begin
        valid_q[wr_idx] <= 1'b1;
      end
    end
  end

  // ====================
  // select
  // ====================
  generate
    if (IN_ORDER) begin : g_in_order
      // circular order, only the head may leave
      idx_t head_q;
      idx_t tail_q;

      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          head_q <= '0;
          tail_q <= '0;
        end else begin
          if (take) begin
            head_q <= (head_q == idx_t'(RS_SIZE - 1)) ? '0 : head_q + 1'b1;
          end
          if (wr_fire) begin
            tail_q <= (tail_q == idx_t'(RS_SIZE - 1)) ? '0 : tail_q + 1'b1;
          end
        end
      end

      assign wr_idx    = tail_q;
      assign full      = valid_q[tail_q];
      assign sel_idx   = head_q;
      assign sel_valid = valid_q[head_q] && rdy0_q[head_q] && rdy1_q[head_q];
    end else begin : g_out_of_order
      // lowest ready entry wins, lowest free slot is filled
      always_comb begin
        sel_valid = 1'b0;
        sel_idx   = '0;
        wr_idx    = '0;
        for (int i = RS_SIZE - 1; i >= 0; i--) begin
          if (valid_q[i] && rdy0_q[i] && rdy1_q[i]) begin
            sel_valid = 1'b1;
            sel_idx   = idx_t'(i);
          end
          if (!valid_q[i]) begin
            wr_idx = idx_t'(i);
          end
        end
      end

      assign full = &valid_q;
    end
  endgenerate

  // ====================
  // issue register
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      issue_valid_o <= 1'b0;
    end else if (load) begin
      issue_valid_o <= sel_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      issue_base_o <= base_q[sel_idx];
      issue_op_o   <= op_q[sel_idx];
    end
  end

  a_issue_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (issue_valid_o && !issue_ready_i) |=>
      (issue_valid_o && $stable(issue_base_o) && $stable(issue_op_o)));

  // the write slot must not hold a live entry
  a_wr_slot_free: assert property (@(posedge clk) disable iff (!rst_n)
    wr_fire |-> !valid_q[wr_idx]);

endmodule

`default_nettype wire

//--- hdl/scheduler.sv
`timescale 1ns/1ps
`default_nettype none

module scheduler import sched_pkg::*; #(
  parameter int ALU_RS_SIZE = 8,
  parameter int MEM_RS_SIZE = 4
) (
  input  wire                  clk,
  input  wire                  rst_n,
  // request
  input  logic                 req_valid_i,
  input  instr_type_e          req_type_i,
  input  logic  [2:0]          req_op_i,
  input  areg_t                req_src0_i,
  input  areg_t                req_src1_i,
  input  areg_t                req_dest_i,
  output logic                 req_ready_o,
  // commit
  input  logic                 free_valid_i,
  input  preg_t                free_preg_i,
  // write-back
  input  logic  [WB_WIDTH-1:0] wb_valid_i,
  input  preg_t [WB_WIDTH-1:0] wb_pdest_i,
  // alu issue
  output logic                 alu_issue_valid_o,
  output issue_base_t          alu_issue_base_o,
  output alu_op_e              alu_issue_op_o,
  input  logic                 alu_issue_ready_i,
  // memory issue
  output logic                 mem_issue_valid_o,
  output issue_base_t          mem_issue_base_o,
  output mem_op_e              mem_issue_op_o,
  input  logic                 mem_issue_ready_i
);

  logic  fl_alloc;
  preg_t fl_preg;
  logic  fl_empty;
  areg_t rt_src0;
  areg_t rt_src1;
  areg_t rt_dest;
  logic  rt_rename;
  preg_t rt_new_preg;
  preg_t rt_psrc0;
  preg_t rt_psrc1;
  logic  rt_src0_ready;
  logic  rt_src1_ready;

  rs_write_if #(.op_t(alu_op_e)) alu_wr_if ();
  rs_write_if #(.op_t(mem_op_e)) mem_wr_if ();

  free_list #(
    .PHY_REGS (PHY_REGS)
  ) free_list0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .alloc_i      (fl_alloc),
    .alloc_preg_o (fl_preg),
    .empty_o      (fl_empty),
    .free_valid_i (free_valid_i),
    .free_preg_i  (free_preg_i)
  );

  rename_table #(
    .PHY_REGS (PHY_REGS)
  ) rename_table0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .src0_i       (rt_src0),
    .src1_i       (rt_src1),
    .dest_i       (rt_dest),
    .rename_i     (rt_rename),
    .new_preg_i   (rt_new_preg),
    .psrc0_o      (rt_psrc0),
    .psrc1_o      (rt_psrc1),
    .src0_ready_o (rt_src0_ready),
    .src1_ready_o (rt_src1_ready),
    .wb_valid_i   (wb_valid_i),
    .wb_pdest_i   (wb_pdest_i)
  );

  rename_dispatch rename_dispatch0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid_i  (req_valid_i),
    .req_type_i   (req_type_i),
    .req_op_i     (req_op_i),
    .req_src0_i   (req_src0_i),
    .req_src1_i   (req_src1_i),
    .req_dest_i   (req_dest_i),
    .req_ready_o  (req_ready_o),
    .alloc_o      (fl_alloc),
    .alloc_preg_i (fl_preg),
    .empty_i      (fl_empty),
    .src0_o       (rt_src0),
    .src1_o       (rt_src1),
    .dest_o       (rt_dest),
    .rename_o     (rt_rename),
    .new_preg_o   (rt_new_preg),
    .psrc0_i      (rt_psrc0),
    .psrc1_i      (rt_psrc1),
    .src0_ready_i (rt_src0_ready),
    .src1_ready_i (rt_src1_ready),
    .alu_wr       (alu_wr_if.dispatch),
    .mem_wr       (mem_wr_if.dispatch)
  );

  // ====================
  // stations
  // ====================
  reservation_station #(
    .RS_SIZE  (ALU_RS_SIZE),
    .IN_ORDER (1'b0),
    .op_t     (alu_op_e)
  ) alu_rs (
    .clk           (clk),
    .rst_n         (rst_n),
    .wr            (alu_wr_if.station),
    .wb_valid_i    (wb_valid_i),
    .wb_pdest_i    (wb_pdest_i),
    .issue_valid_o (alu_issue_valid_o),
    .issue_base_o  (alu_issue_base_o),
    .issue_op_o    (alu_issue_op_o),
    .issue_ready_i (alu_issue_ready_i)
  );

  // loads and stores leave in program order
  reservation_station #(
    .RS_SIZE  (MEM_RS_SIZE),
    .IN_ORDER (1'b1),
    .op_t     (mem_op_e)
  ) mem_rs (
    .clk           (clk),
    .rst_n         (rst_n),
    .wr            (mem_wr_if.station),
    .wb_valid_i    (wb_valid_i),
    .wb_pdest_i    (wb_pdest_i),
    .issue_valid_o (mem_issue_valid_o),
    .issue_base_o  (mem_issue_base_o),
    .issue_op_o    (mem_issue_op_o),
    .issue_ready_i (mem_issue_ready_i)
  );

endmodule

`default_nettype wire

//--- bench/tb_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

module tb_scheduler import sched_pkg::*; ();

  localparam int MAX_ENTRIES = 64;
  localparam int FILLERS     = 17;

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic                 req_valid_i;
  instr_type_e          req_type_i;
  logic  [2:0]          req_op_i;
  areg_t                req_src0_i;
  areg_t                req_src1_i;
  areg_t                req_dest_i;
  logic                 req_ready_o;
  logic                 free_valid_i;
  preg_t                free_preg_i;
  logic  [WB_WIDTH-1:0] wb_valid_i;
  preg_t [WB_WIDTH-1:0] wb_pdest_i;
  logic                 alu_issue_valid_o;
  issue_base_t          alu_issue_base_o;
  alu_op_e              alu_issue_op_o;
  logic                 alu_issue_ready_i;
  logic                 mem_issue_valid_o;
  issue_base_t          mem_issue_base_o;
  mem_op_e              mem_issue_op_o;
  logic                 mem_issue_ready_i;

  // expected stream of file lines followed by recycling requests
  logic        exp_type  [MAX_ENTRIES];
  logic [2:0]  exp_op    [MAX_ENTRIES];
  areg_t       exp_src0  [MAX_ENTRIES];
  areg_t       exp_src1  [MAX_ENTRIES];
  areg_t       exp_dest  [MAX_ENTRIES];
  issue_base_t exp_base  [MAX_ENTRIES];
  logic        issued    [MAX_ENTRIES];
  int          n_entries = 0;
  int          n_file    = 0;
  int          n_issued  = 0;
  int          n_errors  = 0;
  int          n_checks  = 0;

  // registers renamed but not yet written back
  logic [PHY_REGS-1:0] pend;
  preg_t       wbq_preg [$];
  int          wbq_due  [$];
  int          cyc      = 0;
  integer      seed     = 78;
  logic [31:0] rnd_rdy;
  logic [31:0] rnd_dly;
  logic        hold      [2];
  issue_base_t last_base [2];
  logic [2:0]  last_op   [2];
  preg_t       mem_pdests [$];

  scheduler dut0 (.*);

  always #5 clk = ~clk;

  // ====================
  // compare tasks
  // ====================
  task automatic report_error(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    n_errors++;
  endtask

  task automatic check_base(input string name, input issue_base_t exp, input issue_base_t act);
    n_checks++;
    if (act !== exp) begin
      $display("CHECK FAILED at %0t ns: %s expected %h got %h", $time, name, exp, act);
      n_errors++;
    end
  endtask

  task automatic check_preg(input string name, input preg_t exp, input preg_t act);
    n_checks++;
    if (act !== exp) begin
      $display("CHECK FAILED at %0t ns: %s expected %0d got %0d", $time, name, exp, act);
      n_errors++;
    end
  endtask

  task automatic check_op(input string name, input logic [2:0] exp, input logic [2:0] act);
    n_checks++;
    if (act !== exp) begin
      $display("CHECK FAILED at %0t ns: %s expected %0d got %0d", $time, name, exp, act);
      n_errors++;
    end
  endtask

  // ====================
  // stream helpers
  // ====================
  function automatic int add_entry(input logic t, input logic [2:0] op, input areg_t s0,
                                   input areg_t s1, input areg_t d, input preg_t p0,
                                   input preg_t p1, input preg_t pd);
    exp_type[n_entries] = t;
    exp_op[n_entries]   = op;
    exp_src0[n_entries] = s0;
    exp_src1[n_entries] = s1;
    exp_dest[n_entries] = d;
    exp_base[n_entries] = '{psrc0: p0, psrc1: p1, pdest: pd, dest_valid: (d != '0)};
    issued[n_entries]   = 1'b0;
    n_entries++;
    return n_entries - 1;
  endfunction

  task automatic drive_entry(input int k);
    req_valid_i <= 1'b1;
    req_type_i  <= instr_type_e'(exp_type[k]);
    req_op_i    <= exp_op[k];
    req_src0_i  <= exp_src0[k];
    req_src1_i  <= exp_src1[k];
    req_dest_i  <= exp_dest[k];
  endtask

  // returns on the transfer edge
  task automatic wait_accept(input int k);
    @(negedge clk);
    while (!req_ready_o) begin
      @(negedge clk);
    end
    @(posedge clk);
    if (exp_base[k].dest_valid) begin
      pend[exp_base[k].pdest] = 1'b1;
    end
  endtask

  task automatic send_entry(input int k);
    drive_entry(k);
    wait_accept(k);
  endtask

  task automatic wait_drain();
    while (n_issued < n_entries) begin
      @(negedge clk);
    end
  endtask

  // ====================
  // issue monitor
  // ====================
  task automatic record_issue(input int p, input issue_base_t b, input logic [2:0] op);
    int found;
    int dly;
    found = -1;
    for (int k = 0; k < n_entries; k++) begin
      if (!issued[k] && exp_type[k] == p[0]) begin
        // memory leaves in order and alu is matched by its destination
        if (p == 1 || exp_base[k].pdest == b.pdest) begin
          found = k;
          break;
        end
      end
    end
    if (found < 0) begin
      report_error($sformatf("unexpected issue on port %0d with pdest %0d", p, b.pdest));
    end else begin
      issued[found] = 1'b1;
      n_issued++;
      check_base(p == 0 ? "alu_issue_base_o" : "mem_issue_base_o", exp_base[found], b);
      check_op(p == 0 ? "alu_issue_op_o" : "mem_issue_op_o", exp_op[found], op);
      if (p == 1) begin
        mem_pdests.push_back(b.pdest);
      end
      if (b.dest_valid) begin
        rnd_dly = $random(seed);
        dly     = 1 + int'(rnd_dly[1:0]);
        wbq_preg.push_back(b.pdest);
        wbq_due.push_back(cyc + dly);
      end
    end
  endtask

  task automatic monitor_port(input int p, input logic v, input logic r,
                              input issue_base_t b, input logic [2:0] op);
    if (hold[p]) begin
      if (!v) begin
        report_error($sformatf("issue valid on port %0d dropped while stalled", p));
      end else begin
        check_base(p == 0 ? "alu_issue_base_o" : "mem_issue_base_o", last_base[p], b);
        check_op(p == 0 ? "alu_issue_op_o" : "mem_issue_op_o", last_op[p], op);
      end
    end
    // sources of a new issue must already be written back
    if (v && !hold[p]) begin
      if (b.psrc0 != '0 && pend[b.psrc0]) begin
        report_error($sformatf("issued before write-back of p%0d", b.psrc0));
      end
      if (b.psrc1 != '0 && pend[b.psrc1]) begin
        report_error($sformatf("issued before write-back of p%0d", b.psrc1));
      end
    end
    if (v && r) begin
      record_issue(p, b, op);
    end
    hold[p]      = v && !r;
    last_base[p] = b;
    last_op[p]   = op;
  endtask

  always @(negedge clk) begin
    if (rst_n) begin
      monitor_port(0, alu_issue_valid_o, alu_issue_ready_i, alu_issue_base_o,
                   3'(alu_issue_op_o));
      monitor_port(1, mem_issue_valid_o, mem_issue_ready_i, mem_issue_base_o,
                   {1'b0, mem_issue_op_o});
    end
  end

  // random back-pressure
  always @(posedge clk) begin
    if (rst_n) begin
      rnd_rdy = $random(seed);
      alu_issue_ready_i <= rnd_rdy[0] | rnd_rdy[1];
      mem_issue_ready_i <= rnd_rdy[2] | rnd_rdy[3];
    end
  end

  // write-back model on port 0
  always @(posedge clk) begin
    cyc = cyc + 1;
    wb_valid_i <= '0;
    wb_pdest_i <= '0;
    for (int i = 0; i < wbq_preg.size(); i++) begin
      if (wbq_due[i] <= cyc) begin
        wb_valid_i    <= 2'b01;
        wb_pdest_i[0] <= wbq_preg[i];
        pend[wbq_preg[i]] = 1'b0;
        wbq_preg.delete(i);
        wbq_due.delete(i);
        break;
      end
    end
  end

  initial begin
    wait (n_file > 0);
    repeat (n_file * 60) @(posedge clk);
    $display("watchdog expired with %0d of %0d instructions issued", n_issued, n_entries);
    $display("Testbench failed");
    $finish;
  end

  // ====================
  // main sequence
  // ====================
  initial begin
    int    fd;
    int    code;
    int    k;
    int    f[8];
    int    err_mark;
    string line;

    rst_n             = 1'b0;
    req_valid_i       = 1'b0;
    req_type_i        = ALU_INSTR;
    req_op_i          = '0;
    req_src0_i        = '0;
    req_src1_i        = '0;
    req_dest_i        = '0;
    free_valid_i      = 1'b0;
    free_preg_i       = '0;
    wb_valid_i        = '0;
    wb_pdest_i        = '0;
    alu_issue_ready_i = 1'b0;
    mem_issue_ready_i = 1'b0;
    pend              = '0;
    hold[0]           = 1'b0;
    hold[1]           = 1'b0;

    fd = $fopen("bench/sched_input.txt", "r");
    if (fd == 0) begin
      $display("cannot open bench/sched_input.txt");
      $display("Testbench failed");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code <= 0 || line.len() == 0 || line[0] == "#") begin
          continue;
        end
        code = $sscanf(line, "%d %d %d %d %d %d %d %d",
                       f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
        if (code == 8) begin
          k = add_entry(f[0][0], f[1][2:0], areg_t'(f[2]), areg_t'(f[3]), areg_t'(f[4]),
                        preg_t'(f[5]), preg_t'(f[6]), preg_t'(f[7]));
        end
      end
      $fclose(fd);
      n_file = n_entries;

      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      if (!req_ready_o || alu_issue_valid_o || mem_issue_valid_o) begin
        report_error("reset state wrong on ready or issue valid outputs");
      end

      // test 1 covers renaming, readiness, memory order and back-pressure
      err_mark = n_errors;
      @(posedge clk);
      for (int i = 0; i < n_file; i++) begin
        send_entry(i);
      end
      req_valid_i <= 1'b0;
      wait_drain();
      $display("test 1 file stream of %0d instructions: %0d errors", n_file,
               n_errors - err_mark);

      // test 2 exhausts the free list and then recycles
      err_mark = n_errors;
      @(posedge clk);
      for (int i = 0; i < FILLERS; i++) begin
        k = add_entry(1'b0, 3'd0, '0, '0, areg_t'(1), '0, '0, preg_t'(47 + i));
        send_entry(k);
      end
      req_valid_i <= 1'b0;
      wait_drain();
      @(posedge clk);
      k = add_entry(1'b1, 3'd0, '0, '0, areg_t'(2), '0, '0, preg_t'(33));
      drive_entry(k);
      repeat (6) begin
        @(negedge clk);
        if (req_ready_o) begin
          report_error("request accepted with an empty free list");
        end
      end
      @(posedge clk);
      free_valid_i <= 1'b1;
      free_preg_i  <= preg_t'(33);
      @(posedge clk);
      free_valid_i <= 1'b0;
      wait_accept(k);
      free_valid_i <= 1'b1;
      free_preg_i  <= preg_t'(35);
      k = add_entry(1'b1, 3'd0, '0, '0, areg_t'(3), '0, '0, preg_t'(35));
      drive_entry(k);
      @(posedge clk);
      free_valid_i <= 1'b0;
      wait_accept(k);
      req_valid_i <= 1'b0;
      wait_drain();
      check_preg("mem_issue_base_o.pdest", preg_t'(33), mem_pdests[mem_pdests.size() - 2]);
      check_preg("mem_issue_base_o.pdest", preg_t'(35), mem_pdests[mem_pdests.size() - 1]);
      // catch any late duplicate issue
      repeat (20) @(posedge clk);
      $display("test 2 free-list recycling: %0d errors", n_errors - err_mark);

      $display("tests 2, checks %0d, errors %0d", n_checks, n_errors);
      if (n_errors == 0) begin
        $display("Testbench passed");
      end else begin
        $display("Testbench failed");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- bench/sched_input.txt
# type(0 alu, 1 mem) op src0 src1 dest | expected psrc0 psrc1 pdest
# decimal columns, one instruction per line
0 0 2 3 1 2 3 32
0 1 1 5 4 32 5 33
1 0 4 0 6 33 0 34
0 2 6 1 7 34 32 35
1 2 7 6 0 35 34 0
0 3 0 0 1 0 0 36
0 4 1 1 8 36 36 37
1 1 8 0 9 37 0 38
1 3 9 2 0 38 2 0
0 5 9 4 10 38 33 39
0 6 12 13 11 12 13 40
0 7 11 10 12 40 39 41
1 0 12 0 13 41 0 42
0 0 13 11 14 42 40 43
1 2 14 13 0 43 42 0
0 1 3 2 15 3 2 44
1 0 15 0 16 44 0 45
0 0 16 14 1 45 43 46

//--- verilog.f
hdl/sched_pkg.sv
hdl/rs_write_if.sv
hdl/free_list.sv
hdl/rename_table.sv
hdl/rename_dispatch.sv
hdl/reservation_station.sv
hdl/scheduler.sv
bench/tb_scheduler.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_scheduler
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Testbench passed" $(LOG); then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
